/* Bender.yml */
package:
  name: data_cache

sources:
  - cachePkg.sv
  - cacheArrays.sv
  - cacheLookup.sv
  - cacheRefill.sv
  - dataCache.sv
  - target: test
    files:
      - dataCacheMemModel.sv
      - dataCacheTb.sv

/* cacheArrays.sv */
`timescale 1ns/10ps

module cacheArrays import cachePkg::*; (
    input  logic                 clk,
    input  logic                 arstN,

    // read port, one cycle latency
    input  logic [SetWidth-1:0]  rdSet,
    output cacheSetT             rdLine,

    // refill and write-hit port
    input  logic                 fillEn,
    input  logic                 fillLast,
    input  logic                 fillWay,
    input  logic [SetWidth-1:0]  fillSet,
    input  logic [WordWidth-1:0] fillWord,
    input  logic [TagWidth-1:0]  fillTag,
    input  logic [DataWidth-1:0] fillData,
    input  logic                 wrHitEn,

    // replacement state
    input  logic                 lruEn,
    input  logic                 lruWay
);

    logic [TagWidth-1:0]  tagMem  [NumWays][NumSets];
    logic [DataWidth-1:0] dataMem [NumWays][NumSets][WordsPerBlock];

    logic [NumSets-1:0][NumWays-1:0] validBits;
    logic [NumSets-1:0]              usedBits;

    logic wordWrite;
    logic blockDone;

    assign wordWrite = fillEn || wrHitEn;
    assign blockDone = fillEn && fillLast;

    // payload storage
    always_ff @(posedge clk) begin
        if (wordWrite) begin
            dataMem[fillWay][fillSet][fillWord] <= fillData;
        end
        if (blockDone) begin
            tagMem[fillWay][fillSet] <= fillTag;
        end
    end

    // valid and LRU state
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validBits <= '0;
            usedBits  <= '0;
        end else begin
            // block turns valid only once all four words are in
            if (blockDone) begin
                validBits[fillSet][fillWay] <= 1'b1;
            end
            // point at the way that was not just touched
            if (lruEn) begin
                usedBits[fillSet] <= ~lruWay;
            end
        end
    end

    // synchronous read of the whole set
    always_ff @(posedge clk) begin
        for (int w = 0; w < NumWays; w++) begin
            rdLine.way[w].valid <= validBits[rdSet][w];
            rdLine.way[w].tag   <= tagMem[w][rdSet];
            for (int i = 0; i < WordsPerBlock; i++) begin
                rdLine.way[w].data[i] <= dataMem[w][rdSet][i];
            end
        end
        rdLine.used <= usedBits[rdSet];
    end

    // refill and write hit are exclusive phases of the second stage
    assert property (@(posedge clk) disable iff (!arstN) !(fillEn && wrHitEn))
        else $error("fill and write-hit update in the same cycle");

endmodule

/* cacheLookup.sv */
`timescale 1ns/10ps

module cacheLookup import cachePkg::*; (
    input  logic                 clk,
    input  logic                 arstN,

    // processor side, wishbone classic slave
    input  wbReqT                cpuReq,
    output wbRspT                cpuRsp,

    // array read
    output logic [SetWidth-1:0]  rdSet,
    input  cacheSetT             rdLine,

    // to and from the second stage
    output lookupResT            res,
    output logic                 resValid,
    input  logic                 resDone,
    input  logic [DataWidth-1:0] rspData
);

    cacheAddrU            inAddr;
    cacheReqT             reqQ;
    lookupResT            resNext;
    logic                 busy;
    logic                 accept;
    logic [NumWays-1:0]   hitVec;
    logic [DataWidth-1:0] hitData;

    assign inAddr.raw = cpuReq.adr;

    // only one request open at a time
    assign accept = !busy && cpuReq.cyc && cpuReq.stb;

    // arrays sample the set in the accept cycle
    assign rdSet = inAddr.fields.set;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy     <= 1'b0;
            resValid <= 1'b0;
        end else if (resDone) begin
            busy     <= 1'b0;
            resValid <= 1'b0;
        end else if (!busy) begin
            busy <= accept;
        end else begin
            resValid <= 1'b1;
        end
    end

    // tag compare against both ways
    always_comb begin
        for (int w = 0; w < NumWays; w++) begin
            hitVec[w] = rdLine.way[w].valid &&
                        (rdLine.way[w].tag == reqQ.addr.fields.tag);
        end
        hitData = rdLine.way[hitVec[1]].data[reqQ.addr.fields.word];
    end

    always_comb begin
        resNext.req       = reqQ;
        resNext.hit       = |hitVec;
        resNext.hitWay    = hitVec[1];
        resNext.victimWay = rdLine.used;
        resNext.rdata     = hitData;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reqQ.addr.raw <= cpuReq.adr;
            reqQ.wdata    <= cpuReq.dat;
            reqQ.we       <= cpuReq.we;
        end
        // rdLine belongs to reqQ only in the cycle after accept
        if (busy && !resValid) begin
            res <= resNext;
        end
    end

    assign cpuRsp.ack = resDone;
    assign cpuRsp.dat = rspData;

    // refill never installs a tag already present in the set
    assert property (@(posedge clk) disable iff (!arstN)
        busy && !resValid |-> $onehot0(hitVec))
        else $error("tag hit in more than one way");

    assert property (@(posedge clk) disable iff (!arstN)
        cpuRsp.ack |-> cpuReq.cyc && cpuReq.stb)
        else $error("processor ack outside of an open cycle");

endmodule

/* cachePkg.sv */
package cachePkg;

    // geometry
    localparam int DataWidth     = 32;
    localparam int TagWidth      = 25;
    localparam int SetWidth      = 3;
    localparam int NumSets       = 1 << SetWidth;
    localparam int WordWidth     = 2;
    localparam int WordsPerBlock = 1 << WordWidth;
    localparam int ByteWidth     = 2;
    localparam int NumWays       = 2;

    // bus address split into cache fields
    typedef struct packed {
        logic [TagWidth-1:0]  tag;
        logic [SetWidth-1:0]  set;
        logic [WordWidth-1:0] word;
        logic [ByteWidth-1:0] byteOfs;
    } cacheAddrT;

    typedef union packed {
        logic [DataWidth-1:0] raw;
        cacheAddrT            fields;
    } cacheAddrU;

    // one captured processor request
    typedef struct packed {
        cacheAddrU            addr;
        logic [DataWidth-1:0] wdata;
        logic                 we;
    } cacheReqT;

    typedef struct packed {
        cacheReqT             req;
        logic                 hit;
        logic                 hitWay;
        logic                 victimWay;
        logic [DataWidth-1:0] rdata;
    } lookupResT;

    // one way of a set, as read from the arrays
    typedef struct packed {
        logic                                    valid;
        logic [TagWidth-1:0]                     tag;
        logic [WordsPerBlock-1:0][DataWidth-1:0] data;
    } cacheWayT;

    // used selects the LRU way of the set
    typedef struct packed {
        cacheWayT [NumWays-1:0] way;
        logic                   used;
    } cacheSetT;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [DataWidth-1:0] adr;
        logic [DataWidth-1:0] dat;
    } wbReqT;

    // wishbone classic, slave to master
    typedef struct packed {
        logic                 ack;
        logic [DataWidth-1:0] dat;
    } wbRspT;

endpackage

/* cacheRefill.sv */
`timescale 1ns/10ps

module cacheRefill import cachePkg::*; (
    input  logic                 clk,
    input  logic                 arstN,

    // from the lookup stage
    input  lookupResT            res,
    input  logic                 resValid,
    output logic                 resDone,
    output logic [DataWidth-1:0] rspData,

    // memory side, wishbone classic master
    output wbReqT                memReq,
    input  wbRspT                memRsp,

    // array updates
    output logic                 fillEn,
    output logic                 fillLast,
    output logic                 fillWay,
    output logic [SetWidth-1:0]  fillSet,
    output logic [WordWidth-1:0] fillWord,
    output logic [TagWidth-1:0]  fillTag,
    output logic [DataWidth-1:0] fillData,
    output logic                 wrHitEn,
    output logic                 lruEn,
    output logic                 lruWay
);

    enum logic [1:0] {sIdle, sFill, sWrite, sResp} state, stateNext;

    logic [WordWidth-1:0] beat;
    logic [DataWidth-1:0] rspQ;
    cacheAddrU            blockAddr;
    logic                 inFill;

    assign inFill = (state == sFill);

    always_comb begin
        stateNext = state;
        resDone   = 1'b0;
        fillEn    = 1'b0;
        fillLast  = 1'b0;
        wrHitEn   = 1'b0;
        lruEn     = 1'b0;
        lruWay    = res.hitWay;
        case (state)
            sIdle: begin
                if (resValid) begin
                    if (res.req.we) begin
                        stateNext = sWrite;
                    end else if (res.hit) begin
                        // read hit is answered straight from the lookup result
                        resDone = 1'b1;
                        lruEn   = 1'b1;
                    end else begin
                        stateNext = sFill;
                    end
                end
            end
            sFill: begin
                if (memRsp.ack) begin
                    fillEn = 1'b1;
                    if (beat == '1) begin
                        fillLast  = 1'b1;
                        lruEn     = 1'b1;
                        lruWay    = res.victimWay;
                        stateNext = sResp;
                    end
                end
            end
            sWrite: begin
                if (memRsp.ack) begin
                    wrHitEn   = res.hit;
                    lruEn     = res.hit;
                    stateNext = sResp;
                end
            end
            default: begin
                resDone   = 1'b1;
                stateNext = sIdle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= sIdle;
            beat  <= '0;
        end else begin
            state <= stateNext;
            // wraps back to zero after the last beat
            if (inFill && memRsp.ack) begin
                beat <= beat + 1'b1;
            end
        end
    end

    // keep the requested word as it passes by
    always_ff @(posedge clk) begin
        if (inFill && memRsp.ack && (beat == res.req.addr.fields.word)) begin
            rspQ <= memRsp.dat;
        end
    end

    assign rspData = (state == sResp) ? rspQ : res.rdata;

    // block base plus beat offset
    always_comb begin
        blockAddr                = res.req.addr;
        blockAddr.fields.word    = beat;
        blockAddr.fields.byteOfs = '0;
        memReq.cyc = inFill || (state == sWrite);
        memReq.stb = inFill || (state == sWrite);
        memReq.we  = (state == sWrite);
        memReq.adr = inFill ? blockAddr.raw : res.req.addr.raw;
        memReq.dat = res.req.wdata;
    end

    assign fillWay  = inFill ? res.victimWay : res.hitWay;
    assign fillSet  = res.req.addr.fields.set;
    assign fillWord = inFill ? beat : res.req.addr.fields.word;
    assign fillTag  = res.req.addr.fields.tag;
    assign fillData = inFill ? memRsp.dat : res.req.wdata;

    // held request until the slave acks
    assert property (@(posedge clk) disable iff (!arstN)
        memReq.stb && !memRsp.ack |=>
            memReq.cyc && memReq.stb && $stable(memReq.adr) && $stable(memReq.we))
        else $error("memory request dropped or changed before ack");

endmodule

/* dataCache.sv */
`timescale 1ns/10ps

module dataCache import cachePkg::*; (
    input  logic  clk,
    input  logic  arstN,

    input  wbReqT cpuReq,
    output wbRspT cpuRsp,

    output wbReqT memReq,
    input  wbRspT memRsp
);

    logic [SetWidth-1:0]  rdSet;
    cacheSetT             rdLine;
    lookupResT            res;
    logic                 resValid;
    logic                 resDone;
    logic [DataWidth-1:0] rspData;

    logic                 fillEn;
    logic                 fillLast;
    logic                 fillWay;
    logic [SetWidth-1:0]  fillSet;
    logic [WordWidth-1:0] fillWord;
    logic [TagWidth-1:0]  fillTag;
    logic [DataWidth-1:0] fillData;
    logic                 wrHitEn;
    logic                 lruEn;
    logic                 lruWay;

    cacheLookup lookup (
        .clk      (clk),
        .arstN    (arstN),
        .cpuReq   (cpuReq),
        .cpuRsp   (cpuRsp),
        .rdSet    (rdSet),
        .rdLine   (rdLine),
        .res      (res),
        .resValid (resValid),
        .resDone  (resDone),
        .rspData  (rspData)
    );

    cacheArrays arrays (
        .clk      (clk),
        .arstN    (arstN),
        .rdSet    (rdSet),
        .rdLine   (rdLine),
        .fillEn   (fillEn),
        .fillLast (fillLast),
        .fillWay  (fillWay),
        .fillSet  (fillSet),
        .fillWord (fillWord),
        .fillTag  (fillTag),
        .fillData (fillData),
        .wrHitEn  (wrHitEn),
        .lruEn    (lruEn),
        .lruWay   (lruWay)
    );

    cacheRefill refill (
        .clk      (clk),
        .arstN    (arstN),
        .res      (res),
        .resValid (resValid),
        .resDone  (resDone),
        .rspData  (rspData),
        .memReq   (memReq),
        .memRsp   (memRsp),
        .fillEn   (fillEn),
        .fillLast (fillLast),
        .fillWay  (fillWay),
        .fillSet  (fillSet),
        .fillWord (fillWord),
        .fillTag  (fillTag),
        .fillData (fillData),
        .wrHitEn  (wrHitEn),
        .lruEn    (lruEn),
        .lruWay   (lruWay)
    );

endmodule

/* dataCacheMemModel.sv */
`timescale 1ns/10ps

module dataCacheMemModel import cachePkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  wbReqT req,
    output wbRspT rsp
);

    // 4 KB window, 1024 words
    logic [DataWidth-1:0] words [1024];
    logic [9:0]           idx;
    logic                 armed;
    logic                 ackNow;
    int                   waitCnt;

    assign idx    = req.adr[11:2];
    assign ackNow = req.cyc && req.stb && !rsp.ack && armed && (waitCnt == 0);

    // word address XOR a fixed mask
    initial begin
        for (int a = 0; a < 1024; a++) begin
            words[a] <= a ^ 32'hA5A50000;
        end
    end

    always @(posedge clk) begin
        if (ackNow && req.we) begin
            words[idx] <= req.dat;
        end
    end

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rsp     <= '0;
            armed   <= 1'b0;
            waitCnt <= 0;
        end else begin
            rsp.ack <= 1'b0;
            if (req.cyc && req.stb && !rsp.ack) begin
                if (!armed) begin
                    // extra wait of 0 to 3 cycles
                    armed   <= 1'b1;
                    waitCnt <= $urandom % 4;
                end else if (waitCnt != 0) begin
                    waitCnt <= waitCnt - 1;
                end else begin
                    armed   <= 1'b0;
                    rsp.ack <= 1'b1;
                    rsp.dat <= words[idx];
                end
            end
        end
    end

endmodule

/* dataCacheTb.sv */
`timescale 1ns/10ps

module dataCacheTb import cachePkg::*; ();

    logic  clk = 1'b0;
    logic  arstN;
    wbReqT cpuReq;
    wbRspT cpuRsp;
    wbReqT memReq;
    wbRspT memRsp;

    // mirror of the memory contents
    logic [DataWidth-1:0] shadow [1024];

    string                testName;
    logic [DataWidth-1:0] curAddr;
    logic [DataWidth-1:0] curWdata;
    logic [DataWidth-1:0] expData;
    logic [DataWidth-1:0] fillBase;
    logic                 curWe;
    logic                 justReleased = 1'b1;
    int                   expReads;
    int                   cycleCount;
    int                   startCycle;
    int                   memReadTotal;
    int                   memWriteTotal;
    int                   ackTotal;
    int                   readsAtStart;
    int                   writesAtStart;
    int                   acksAtStart;
    int                   requestCount;
    int                   errorCount;

    always #10 clk = ~clk;

    dataCache dut (
        .clk    (clk),
        .arstN  (arstN),
        .cpuReq (cpuReq),
        .cpuRsp (cpuRsp),
        .memReq (memReq),
        .memRsp (memRsp)
    );

    dataCacheMemModel mem (
        .clk   (clk),
        .arstN (arstN),
        .req   (memReq),
        .rsp   (memRsp)
    );

    // bus traffic counters
    always @(posedge clk) begin
        cycleCount   <= cycleCount + 1;
        justReleased <= !arstN;
        if (memReq.cyc && memRsp.ack && memReq.we) begin
            memWriteTotal <= memWriteTotal + 1;
        end
        if (memReq.cyc && memRsp.ack && !memReq.we) begin
            memReadTotal <= memReadTotal + 1;
        end
        if (cpuRsp.ack) begin
            ackTotal <= ackTotal + 1;
        end
    end

    task automatic reportMismatch(input logic [31:0] expected, input logic [31:0] actual);
        errorCount++;
        $display("[ERROR] %s: expected 0x%h, actual 0x%h", testName, expected, actual);
    endtask

    task automatic reportFault(input string what);
        errorCount++;
        $display("%s: %s", testName, what);
    endtask

    // covers reset and the first cycle after it
    assert property (@(posedge clk) (!arstN || justReleased) |->
        !cpuRsp.ack && !memReq.cyc && !memReq.stb)
        else reportFault("bus activity during or right after reset");

    assert property (@(posedge clk) disable iff (!arstN)
        cpuRsp.ack && !curWe |-> cpuRsp.dat == expData)
        else reportMismatch(expData, $sampled(cpuRsp.dat));

    assert property (@(posedge clk) disable iff (!arstN)
        cpuRsp.ack && expReads >= 0 |-> memReadTotal - readsAtStart == expReads)
        else reportMismatch(expReads, $sampled(memReadTotal) - readsAtStart);

    assert property (@(posedge clk) disable iff (!arstN)
        cpuRsp.ack |-> memWriteTotal - writesAtStart == int'(curWe))
        else reportMismatch(int'(curWe), $sampled(memWriteTotal) - writesAtStart);

    // hit latency counted from the accept edge
    assert property (@(posedge clk) disable iff (!arstN)
        cpuRsp.ack && !curWe && expReads == 0 |-> cycleCount - startCycle == 2)
        else reportMismatch(2, $sampled(cycleCount) - startCycle);

    // refill beats walk the block upward
    assert property (@(posedge clk) disable iff (!arstN)
        memReq.cyc && !memReq.we && memRsp.ack |->
            memReq.adr == fillBase + 4 * (memReadTotal - readsAtStart))
        else reportMismatch(fillBase + 4 * ($sampled(memReadTotal) - readsAtStart),
                            $sampled(memReq.adr));

    assert property (@(posedge clk) disable iff (!arstN)
        memReq.cyc && memReq.we && memRsp.ack |-> memReq.adr == curAddr)
        else reportMismatch(curAddr, $sampled(memReq.adr));

    assert property (@(posedge clk) disable iff (!arstN)
        memReq.cyc && memReq.we && memRsp.ack |-> memReq.dat == curWdata)
        else reportMismatch(curWdata, $sampled(memReq.dat));

    assert property (@(posedge clk) disable iff (!arstN)
        memReq.stb && !memRsp.ack |=> memReq.cyc && memReq.stb &&
            $stable(memReq.adr) && $stable(memReq.we) && $stable(memReq.dat))
        else reportFault("memory request changed before its ack");

    assert property (@(posedge clk) disable iff (!arstN)
        cpuRsp.ack |-> cpuReq.cyc && cpuReq.stb && ackTotal == acksAtStart)
        else reportFault("processor ack outside a request or repeated");

    // reads = -1 leaves the refill count unchecked
    task automatic runRequest(input string name, input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, input int reads);
        @(posedge clk);
        #2;
        testName      = name;
        curAddr       = addr;
        curWe         = we;
        curWdata      = wdata;
        fillBase      = {addr[31:4], 4'h0};
        expReads      = we ? 0 : reads;
        if (we) begin
            shadow[addr[11:2]] = wdata;
        end
        expData       = shadow[addr[11:2]];
        startCycle    = cycleCount;
        readsAtStart  = memReadTotal;
        writesAtStart = memWriteTotal;
        acksAtStart   = ackTotal;
        requestCount++;
        cpuReq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, dat: wdata};
        do begin
            @(negedge clk);
        end while (!cpuRsp.ack);
    endtask

    initial begin
        #(200 * 40 * 20);
        $display("watchdog expired before all requests completed");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [DataWidth-1:0] randAddr;
        logic                 randWe;
        void'($urandom(92));
        arstN    = 1'b0;
        cpuReq   = '0;
        testName = "reset";
        for (int a = 0; a < 1024; a++) begin
            shadow[a] = a ^ 32'hA5A50000;
        end
        repeat (8) @(posedge clk);
        #2;
        arstN = 1'b1;

        runRequest("first read", 1'b0, 32'h100, '0, 4);
        runRequest("same block", 1'b0, 32'h108, '0, 0);
        runRequest("repeat read", 1'b0, 32'h100, '0, 0);
        runRequest("write hit", 1'b1, 32'h104, 32'h12345678, 0);
        runRequest("read after write hit", 1'b0, 32'h104, '0, 0);
        runRequest("write miss", 1'b1, 32'h210, 32'h0BADF00D, 0);
        runRequest("read after write miss", 1'b0, 32'h210, '0, 4);

        // A, B and C share set 2
        runRequest("lru read A", 1'b0, 32'h020, '0, 4);
        runRequest("lru read B", 1'b0, 32'h0A0, '0, 4);
        runRequest("lru touch A", 1'b0, 32'h020, '0, 0);
        runRequest("lru read C", 1'b0, 32'h120, '0, 4);
        runRequest("lru A kept", 1'b0, 32'h024, '0, 0);
        runRequest("lru B evicted", 1'b0, 32'h0A8, '0, 4);

        for (int i = 0; i < 150; i++) begin
            randAddr = ($urandom % 1024) << 2;
            randWe   = ($urandom % 3) == 0;
            runRequest("random", randWe, randAddr, $urandom, -1);
        end

        @(posedge clk);
        #2;
        cpuReq = '0;
        repeat (4) @(posedge clk);
        $display("requests %0d, memory reads %0d, memory writes %0d, errors %0d",
                 requestCount, memReadTotal, memWriteTotal, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
cachePkg.sv
cacheArrays.sv
cacheLookup.sv
cacheRefill.sv
dataCache.sv
dataCacheMemModel.sv
dataCacheTb.sv
